//--- logic/decompose_pkg.sv
// ------------------------------------------------
// Shared definitions for the ML-DSA decompose stage
// Constants for gamma2 = (q-1)/32, lane count
// Vector typedefs for coefficients and results
// Packed structs for lane traffic and output words
// ------------------------------------------------

package decompose_pkg;

    // ------------------------------------------------
    // Constants of the standard
    // ------------------------------------------------

    // Field modulus q = 2^23 - 2^13 + 1
    localparam logic [31:0] MLDSA_Q = 32'd8380417;

    // Low-order rounding range for ML-DSA-65 and ML-DSA-87
    localparam logic [31:0] MLDSA_GAMMA2 = 32'd261888;

    // 2*gamma2 = 2^19 - 2^9, the divisor used by every lane
    localparam logic [31:0] MLDSA_2GAMMA2 = 32'd523776;

    // Rejection margin of the signing loop
    localparam logic [31:0] MLDSA_BETA = 32'd196;

    // Any |r0| at or above this value rejects the signature attempt
    localparam logic [31:0] NORM_BOUND = MLDSA_GAMMA2 - MLDSA_BETA;

    // One lane per coefficient of an input word
    localparam int NUM_LANES = 4;

    // Largest high part, since (q-1)/(2*gamma2) = 16 folds back to 0
    localparam int R1_MAX = 15;

    // ------------------------------------------------
    // Vector types
    // ------------------------------------------------

    // Lazily reduced coefficient in [0, 2q)
    typedef logic [23:0] coeff_lazy_t;
    // Fully reduced coefficient in [0, q)
    typedef logic [22:0] coeff_t;
    // Remainder modulo 2*gamma2
    typedef logic [18:0] mod2g2_t;
    // Centered low part in (-gamma2, gamma2], two's complement
    typedef logic signed [19:0] r0_t;
    // High part in [0, 15]
    typedef logic [3:0] r1_t;
    // Four packed high parts, lane k in nibble k
    typedef logic [15:0] w1_word_t;

    // ------------------------------------------------
    // Structs and word arrays
    // ------------------------------------------------

    typedef struct packed {
        logic   valid;
        coeff_t coeff;
    } lane_in_t;

    typedef struct packed {
        logic valid;
        r1_t  r1;
        r0_t  r0;
    } lane_out_t;

    typedef coeff_lazy_t [NUM_LANES-1:0] coeff_word_t;
    typedef r0_t [NUM_LANES-1:0] r0_word_t;

endpackage

//--- logic/decompose_mod_2gamma2.sv
// ------------------------------------------------
// Two-stage reduction modulo 2*gamma2 = 2^19 - 2^9
// Stage 1 folds the top bits into the low 19 bits
// Stage 2 does one conditional subtraction
// Wrap output marks that the subtraction was taken
// ------------------------------------------------

`timescale 1ns/1ns

module decompose_mod_2gamma2 (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   zeroize_i,
    input  logic                   add_en_i,
    input  decompose_pkg::coeff_t  opa_i,
    output decompose_pkg::mod2g2_t res_o,
    output logic                   wrap_o,
    output logic                   ready_o
);

    // Top bits of the input moved to weight 2^9
    decompose_pkg::mod2g2_t hi_shift;
    decompose_pkg::mod2g2_t sum_s1;
    logic                   carry_s1;

    decompose_pkg::mod2g2_t sum_q;
    logic                   carry_q;

    decompose_pkg::mod2g2_t diff_s2;
    logic                   carry_s2;

    // ------------------------------------------------
    // Stage 1
    // ------------------------------------------------

    // Since 2^19 = 2*gamma2 + 2^9, each unit of r[22:19] contributes 2^9
    assign hi_shift = {6'b0, opa_i[22:19], 9'b0};

    // The folded sum stays below 2 * (2*gamma2), so one subtraction is enough later
    assign {carry_s1, sum_s1} = {1'b0, opa_i[18:0]} + {1'b0, hi_shift};

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            sum_q   <= '0;
            carry_q <= 1'b0;
        end else if (zeroize_i) begin
            sum_q   <= '0;
            carry_q <= 1'b0;
        end else if (add_en_i) begin
            sum_q   <= sum_s1;
            carry_q <= carry_s1;
        end
    end

    // Result is valid one cycle after the enable
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            ready_o <= 1'b0;
        end else if (zeroize_i) begin
            ready_o <= 1'b0;
        end else begin
            ready_o <= add_en_i;
        end
    end

    // ------------------------------------------------
    // Stage 2
    // ------------------------------------------------

    // Subtract 2*gamma2 as the complement plus a carry-in of one
    assign {carry_s2, diff_s2} = {1'b0, sum_q}
                               + {1'b0, ~decompose_pkg::mod2g2_t'(decompose_pkg::MLDSA_2GAMMA2)}
                               + 20'd1;

    // Odd carry parity means the 20-bit sum reached 2*gamma2
    assign wrap_o = carry_q ^ carry_s2;
    assign res_o  = wrap_o ? diff_s2 : sum_q;

endmodule

//--- logic/decompose_lane.sv
// ------------------------------------------------
// One decompose lane
// Mod block gives r mod 2*gamma2 and a wrap bit
// Centering of r0 and quotient forming for r1
// Fold of the q-1 corner to r1 = 0
// ------------------------------------------------

`timescale 1ns/1ns

module decompose_lane (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     zeroize_i,
    input  decompose_pkg::lane_in_t  lane_i,
    output decompose_pkg::lane_out_t lane_o
);

    decompose_pkg::mod2g2_t rem;
    logic                   wrap;
    logic                   rem_ready;

    // Top coefficient bits, delayed to line up with the mod block output
    logic [3:0]             hi_q;

    // Quotient before and after centering, 16 needs the fifth bit
    logic [4:0]             quot;
    logic [4:0]             quot_adj;
    logic                   over_half;
    logic                   corner;

    decompose_pkg::r0_t     r0_cent;
    decompose_pkg::r0_t     r0_fix;
    decompose_pkg::r1_t     r1_fix;

    decompose_mod_2gamma2 i_mod (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .add_en_i  (lane_i.valid),
        .opa_i     (lane_i.coeff),
        .res_o     (rem),
        .wrap_o    (wrap),
        .ready_o   (rem_ready)
    );

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            hi_q <= '0;
        end else if (zeroize_i) begin
            hi_q <= '0;
        end else if (lane_i.valid) begin
            hi_q <= lane_i.coeff[22:19];
        end
    end

    // ------------------------------------------------
    // Correction logic
    // ------------------------------------------------

    // r = hi * 2*gamma2 + (hi * 2^9 + lo), so floor(r / 2*gamma2) is hi plus the wrap
    assign quot = {1'b0, hi_q} + {4'b0, wrap};

    // A remainder above gamma2 is moved into the negative half of the range
    assign over_half = {13'b0, rem} > decompose_pkg::MLDSA_GAMMA2;
    assign r0_cent   = over_half ? {1'b0, rem} - 20'(decompose_pkg::MLDSA_2GAMMA2)
                                 : {1'b0, rem};
    assign quot_adj  = quot + {4'b0, over_half};

    // A quotient of 16 means r - r0 = q - 1, which the standard maps to r1 = 0
    assign corner = quot_adj > 5'(decompose_pkg::R1_MAX);
    assign r1_fix = corner ? '0 : quot_adj[3:0];
    assign r0_fix = corner ? r0_cent - 20'sd1 : r0_cent;

    // Output register, valid follows the mod block ready
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            lane_o <= '0;
        end else if (zeroize_i) begin
            lane_o <= '0;
        end else begin
            lane_o.valid <= rem_ready;
            if (rem_ready) begin
                lane_o.r1 <= r1_fix;
                lane_o.r0 <= r0_fix;
            end
        end
    end

endmodule

//--- logic/coeff_distributor.sv
// ------------------------------------------------
// Input register and fan-out to the lanes
// Brings each coefficient from [0, 2q) into [0, q)
// ------------------------------------------------

`timescale 1ns/1ns

module coeff_distributor (
    input  logic                                               clk,
    input  logic                                               reset_n,
    input  logic                                               zeroize_i,
    input  logic                                               in_valid_i,
    input  decompose_pkg::coeff_word_t                         coeff_word_i,
    output decompose_pkg::lane_in_t [decompose_pkg::NUM_LANES-1:0] lanes_o
);

    // Reduced coefficient of each lane, before the register
    decompose_pkg::coeff_t reduced [decompose_pkg::NUM_LANES];

    // Set when the lazy coefficient is at or above q
    logic [decompose_pkg::NUM_LANES-1:0] need_sub;

    // ------------------------------------------------
    // Conditional subtraction of q
    // ------------------------------------------------

    for (genvar k = 0; k < decompose_pkg::NUM_LANES; k++) begin : g_reduce
        assign need_sub[k] = {8'b0, coeff_word_i[k]} >= decompose_pkg::MLDSA_Q;

        // One subtraction suffices because the input stays below 2q
        assign reduced[k] = need_sub[k]
                          ? 23'(coeff_word_i[k] - 24'(decompose_pkg::MLDSA_Q))
                          : 23'(coeff_word_i[k]);
    end

    // ------------------------------------------------
    // Lane registers
    // ------------------------------------------------

    // All lanes share the input strobe, so they stay in lockstep
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            lanes_o <= '0;
        end else if (zeroize_i) begin
            lanes_o <= '0;
        end else begin
            for (int k = 0; k < decompose_pkg::NUM_LANES; k++) begin
                lanes_o[k].valid <= in_valid_i;
                // Payload only moves with a valid word
                if (in_valid_i) begin
                    lanes_o[k].coeff <= reduced[k];
                end
            end
        end
    end

endmodule

//--- logic/decompose_collector.sv
// ------------------------------------------------
// Output collector of the decompose stage
// Packs the r1 nibbles into w1 and the r0 values into a word
// Flags any |r0| at or above gamma2 - beta
// ------------------------------------------------

`timescale 1ns/1ns

module decompose_collector (
    input  logic                                                clk,
    input  logic                                                reset_n,
    input  logic                                                zeroize_i,
    input  decompose_pkg::lane_out_t [decompose_pkg::NUM_LANES-1:0] lanes_i,
    output logic                                                out_valid_o,
    output decompose_pkg::w1_word_t                             w1_o,
    output decompose_pkg::r0_word_t                             r0_o,
    output logic                                                norm_fail_o
);

    // Word valid, taken from lane 0 since every lane moves in lockstep
    logic                                word_valid;

    decompose_pkg::w1_word_t             w1_next;
    decompose_pkg::r0_word_t             r0_next;

    // Magnitude of each r0 and its comparison against the bound
    decompose_pkg::r0_t                  r0_abs [decompose_pkg::NUM_LANES];
    logic [decompose_pkg::NUM_LANES-1:0] over_bound;

    assign word_valid = lanes_i[0].valid;

    // ------------------------------------------------
    // Packing and norm check
    // ------------------------------------------------

    for (genvar k = 0; k < decompose_pkg::NUM_LANES; k++) begin : g_pack
        // Lane k lands in nibble k of w1 and element k of the r0 word
        assign w1_next[4*k +: 4] = lanes_i[k].r1;
        assign r0_next[k]        = lanes_i[k].r0;

        // The smallest r0 is -gamma2 + 1 or -gamma2, so the negation cannot overflow
        assign r0_abs[k] = lanes_i[k].r0[19] ? -lanes_i[k].r0 : lanes_i[k].r0;

        assign over_bound[k] = {12'b0, r0_abs[k]} >= decompose_pkg::NORM_BOUND;
    end

    // ------------------------------------------------
    // Output registers
    // ------------------------------------------------

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            out_valid_o <= 1'b0;
            w1_o        <= '0;
            r0_o        <= '0;
            norm_fail_o <= 1'b0;
        end else if (zeroize_i) begin
            out_valid_o <= 1'b0;
            w1_o        <= '0;
            r0_o        <= '0;
            norm_fail_o <= 1'b0;
        end else begin
            out_valid_o <= word_valid;
            // The flag is a strobe that only rises with a valid word
            norm_fail_o <= word_valid & (|over_bound);
            if (word_valid) begin
                w1_o <= w1_next;
                r0_o <= r0_next;
            end
        end
    end

endmodule

//--- logic/decompose_top.sv
// ------------------------------------------------
// Top level of the decompose stage
// Distributor, four decompose lanes, collector
// Output valid follows input valid by 4 cycles
// ------------------------------------------------

`timescale 1ns/1ns

module decompose_top (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       zeroize_i,
    input  logic                       in_valid_i,
    input  decompose_pkg::coeff_word_t coeff_word_i,
    output logic                       out_valid_o,
    output decompose_pkg::w1_word_t    w1_o,
    output decompose_pkg::r0_word_t    r0_o,
    output logic                       norm_fail_o
);

    decompose_pkg::lane_in_t  [decompose_pkg::NUM_LANES-1:0] lane_in;
    decompose_pkg::lane_out_t [decompose_pkg::NUM_LANES-1:0] lane_out;

    // Stage 1: reduce to [0, q) and register per lane
    coeff_distributor i_coeff_distributor (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .in_valid_i   (in_valid_i),
        .coeff_word_i (coeff_word_i),
        .lanes_o      (lane_in)
    );

    // Stages 2 and 3: one decompose per coefficient
    for (genvar k = 0; k < decompose_pkg::NUM_LANES; k++) begin : g_lane
        decompose_lane i_decompose_lane (
            .clk       (clk),
            .reset_n   (reset_n),
            .zeroize_i (zeroize_i),
            .lane_i    (lane_in[k]),
            .lane_o    (lane_out[k])
        );
    end

    // Stage 4: pack the words and check the norm bound
    decompose_collector i_decompose_collector (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .lanes_i     (lane_out),
        .out_valid_o (out_valid_o),
        .w1_o        (w1_o),
        .r0_o        (r0_o),
        .norm_fail_o (norm_fail_o)
    );

endmodule

//--- include/decompose_ref_model.svh
// ------------------------------------------------
// Reference model for the decompose testbench
// Lazy reduction, ML-DSA Decompose and norm flag
// ------------------------------------------------

`ifndef DECOMPOSE_REF_MODEL_SVH
`define DECOMPOSE_REF_MODEL_SVH

// Reduce a coefficient from [0, 2q) to [0, q)
function automatic decompose_pkg::coeff_t ref_reduce(input decompose_pkg::coeff_lazy_t c);
    int unsigned v;
    v = c;
    if (v >= decompose_pkg::MLDSA_Q) begin
        v = v - decompose_pkg::MLDSA_Q;
    end
    return decompose_pkg::coeff_t'(v);
endfunction

// Decompose as in the standard, with the r - r0 = q - 1 case folded to r1 = 0
function automatic void ref_decompose(input  decompose_pkg::coeff_t r,
                                      output decompose_pkg::r1_t    r1,
                                      output decompose_pkg::r0_t    r0);
    int rv;
    int m;
    rv = int'(r);
    m  = rv % int'(decompose_pkg::MLDSA_2GAMMA2);
    // Centered remainder in (-gamma2, gamma2]
    if (m > int'(decompose_pkg::MLDSA_GAMMA2)) begin
        m = m - int'(decompose_pkg::MLDSA_2GAMMA2);
    end
    if (rv - m == int'(decompose_pkg::MLDSA_Q) - 1) begin
        r1 = '0;
        r0 = decompose_pkg::r0_t'(m - 1);
    end else begin
        r1 = decompose_pkg::r1_t'((rv - m) / int'(decompose_pkg::MLDSA_2GAMMA2));
        r0 = decompose_pkg::r0_t'(m);
    end
endfunction

// True when any lane has |r0| at or above gamma2 - beta
function automatic logic ref_norm_fail(input decompose_pkg::r0_word_t r0w);
    logic fail;
    int   v;
    fail = 1'b0;
    for (int k = 0; k < decompose_pkg::NUM_LANES; k++) begin
        v = int'($signed(r0w[k]));
        if (v < 0) begin
            v = -v;
        end
        if (v >= int'(decompose_pkg::NORM_BOUND)) begin
            fail = 1'b1;
        end
    end
    return fail;
endfunction

`endif

//--- verif/decompose_tb.sv
// ------------------------------------------------
// Testbench for the ML-DSA decompose stage
// Stimulus table of boundary, corner, lazy and norm words
// Random words with gaps and a zeroize with words in flight
// Cycle monitor with a 4-cycle latency model and result queue
// ------------------------------------------------

`timescale 1ns/1ns

module decompose_tb;

    `include "decompose_ref_model.svh"

    // One table row with the strobes and the input word
    typedef struct packed {
        logic                       valid;
        logic                       zero;
        decompose_pkg::coeff_word_t word;
    } vec_t;

    // Expected output word
    typedef struct packed {
        decompose_pkg::w1_word_t w1;
        decompose_pkg::r0_word_t r0;
        logic                    nf;
    } exp_t;

    logic                       clk;
    logic                       reset_n;
    logic                       zeroize_i;
    logic                       in_valid_i;
    decompose_pkg::coeff_word_t coeff_word_i;
    logic                       out_valid_o;
    decompose_pkg::w1_word_t    w1_o;
    decompose_pkg::r0_word_t    r0_o;
    logic                       norm_fail_o;

    vec_t       vec_tab[$];
    exp_t       exp_q[$];
    // Valid bits of the words in flight
    // Bit 4 is due at the output
    logic [4:0] pipe_valid = '0;
    // Set while outputs must still read zero after reset or zeroize
    logic       zero_expected = 1'b1;

    decompose_top i_decompose_top (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .in_valid_i   (in_valid_i),
        .coeff_word_i (coeff_word_i),
        .out_valid_o  (out_valid_o),
        .w1_o         (w1_o),
        .r0_o         (r0_o),
        .norm_fail_o  (norm_fail_o)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [79:0] got,
                               input logic [79:0] want);
        if (got !== want) begin
            $display("error %s: got 0x%0h expected 0x%0h", name, got, want);
            $display("Simulation FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic add_vector(input logic valid, input logic zero, input logic [31:0] c0,
                              input logic [31:0] c1, input logic [31:0] c2,
                              input logic [31:0] c3);
        vec_t v;
        v.valid   = valid;
        v.zero    = zero;
        v.word[0] = c0[23:0];
        v.word[1] = c1[23:0];
        v.word[2] = c2[23:0];
        v.word[3] = c3[23:0];
        vec_tab.push_back(v);
    endtask

    // Expected w1, r0 and norm flag of one input word
    function automatic exp_t expected_result(input decompose_pkg::coeff_word_t w);
        exp_t               e;
        decompose_pkg::r1_t r1;
        decompose_pkg::r0_t r0;
        e = '0;
        for (int k = 0; k < decompose_pkg::NUM_LANES; k++) begin
            ref_decompose(ref_reduce(w[k]), r1, r0);
            e.w1[4*k +: 4] = r1;
            e.r0[k]        = r0;
        end
        e.nf = ref_norm_fail(e.r0);
        return e;
    endfunction

    // ------------------------------------------------
    // Monitor sampling at the falling edge
    // ------------------------------------------------

    always @(negedge clk) begin : monitor
        exp_t e;
        int   dropped;
        // An input seen now is captured at the next rising edge and leaves 4 edges later
        pipe_valid = {pipe_valid[3:0], in_valid_i};
        if (in_valid_i) begin
            exp_q.push_back(expected_result(coeff_word_i));
        end
        if (pipe_valid[4]) begin
            e = exp_q.pop_front();
            check_value("out_valid_o", out_valid_o, 1'b1);
            check_value("w1_o", w1_o, e.w1);
            check_value("r0_o", r0_o, e.r0);
            check_value("norm_fail_o", norm_fail_o, e.nf);
            zero_expected = 1'b0;
        end else begin
            check_value("out_valid_o", out_valid_o, 1'b0);
            check_value("norm_fail_o", norm_fail_o, 1'b0);
            if (zero_expected) begin
                check_value("w1_o", w1_o, '0);
                check_value("r0_o", r0_o, '0);
            end
        end
        // Reset or zeroize at the next edge kills every word still inside the pipeline
        if (zeroize_i || !reset_n) begin
            dropped = 0;
            for (int i = 0; i < 4; i++) begin
                if (pipe_valid[i]) begin
                    dropped++;
                end
            end
            pipe_valid[3:0] = '0;
            repeat (dropped) void'(exp_q.pop_back());
            zero_expected = 1'b1;
        end
    end

    // ------------------------------------------------
    // Stimulus table and driver
    // ------------------------------------------------

    initial begin : driver
        integer      seed;
        int          timeout;
        logic [31:0] c [4];
        logic [31:0] q;
        logic [31:0] g2;
        logic [31:0] g22;
        logic [31:0] nb;
        seed         = 32'hebd1;
        q            = decompose_pkg::MLDSA_Q;
        g2           = decompose_pkg::MLDSA_GAMMA2;
        g22          = decompose_pkg::MLDSA_2GAMMA2;
        nb           = decompose_pkg::NORM_BOUND;
        clk          = 1'b0;
        reset_n      = 1'b0;
        zeroize_i    = 1'b0;
        in_valid_i   = 1'b0;
        coeff_word_i = '0;

        // Boundaries of the centering and the largest regular high part
        add_vector(1, 0, 0, g2, g2 + 1, g22 - 1);
        add_vector(1, 0, g22, g22 + 1, 15 * g22, 0);
        // The q-1 corner and the value just below it
        add_vector(1, 0, q - g2, q - g2 + 1, q - 2, q - 1);
        add_vector(1, 0, q - 1 - g2, q - 1, 1, g2);
        // Lazy inputs r + q
        add_vector(1, 0, q, q + g2 + 1, q + q - 1, q + 15 * g22);
        // Idle with junk data must give no output
        add_vector(0, 0, 24'h123456, 24'habcdef, 5, 7);
        // Norm flag just below and at the bound on both signs
        add_vector(1, 0, nb - 1, g22 - nb + 1, 0, 5);
        add_vector(1, 0, 0, nb, 0, 0);
        add_vector(1, 0, 3, 0, 0, g22 - nb);
        add_vector(1, 0, q + nb - 1, 2, q + g22 - nb + 1, 9);
        // Words in every stage and then a single zeroize cycle
        add_vector(1, 0, g2, g2, g2, g2);
        add_vector(1, 0, q - 1, 1, 2, 3);
        add_vector(1, 0, g22, 0, 0, 0);
        add_vector(1, 1, 4, 5, 6, 7);
        for (int i = 0; i < 5; i++) begin
            add_vector(0, 0, 0, 0, 0, 0);
        end
        add_vector(1, 0, g2 + 1, q - 1, q + 1, 15 * g22);

        // Random words in [0, 2q) with a gap after every seventh
        for (int n = 0; n < 40; n++) begin
            for (int k = 0; k < 4; k++) begin
                c[k] = $unsigned($random(seed)) % (2 * q);
            end
            add_vector(1, 0, c[0], c[1], c[2], c[3]);
            if (n % 7 == 6) begin
                add_vector(0, 0, c[3], c[2], c[1], c[0]);
            end
        end

        repeat (4) @(posedge clk);
        reset_n <= 1'b1;

        foreach (vec_tab[i]) begin
            @(posedge clk);
            in_valid_i   <= vec_tab[i].valid;
            zeroize_i    <= vec_tab[i].zero;
            coeff_word_i <= vec_tab[i].word;
        end
        @(posedge clk);
        in_valid_i <= 1'b0;
        zeroize_i  <= 1'b0;

        // Drain the words still in flight
        timeout = 0;
        while ((pipe_valid != '0 || exp_q.size() != 0) && timeout < 20) begin
            @(posedge clk);
            timeout++;
        end
        if (pipe_valid == '0 && exp_q.size() == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Output words were still missing when the drain timed out");
            $display("Simulation FAILED");
            $fatal(1, "drain timeout");
        end
    end

endmodule

//--- vlog.f
+incdir+include
logic/decompose_pkg.sv
logic/decompose_mod_2gamma2.sv
logic/decompose_lane.sv
logic/coeff_distributor.sv
logic/decompose_collector.sv
logic/decompose_top.sv
verif/decompose_tb.sv

//--- Bender.yml
package:
  name: mldsa_decompose

export_include_dirs:
  - include

sources:
  - logic/decompose_pkg.sv
  - logic/decompose_mod_2gamma2.sv
  - logic/decompose_lane.sv
  - logic/coeff_distributor.sv
  - logic/decompose_collector.sv
  - logic/decompose_top.sv
  - target: test
    files:
      - verif/decompose_tb.sv
